//--- audio_pkg.sv
`default_nettype none

package audio_pkg;

    //----------------------------------------
    // sample formats
    //----------------------------------------

    // INMP441 delivers 24-bit two's complement data
    typedef logic signed [23:0] mic_sample_t;

    // offset binary, 128 is silence
    typedef logic [7:0] dac_code_t;

    //----------------------------------------
    // state encodings
    //----------------------------------------

    // receiver position inside the i2s frame
    typedef enum logic [1:0] {
        MIC_WAIT_FRAME,   // after reset, waiting for slot start
        MIC_LEFT_DELAY,   // one-bit i2s delay before msb
        MIC_LEFT_DATA,    // shifting the 24 data bits
        MIC_SKIP          // rest of left slot and whole right slot
    } mic_state_t;

    // player output mode
    typedef enum logic [1:0] {
        PLAYER_IDLE,      // nothing fetched yet, output at midscale
        PLAYER_PLAYING,
        PLAYER_MUTED
    } player_state_t;

endpackage

`default_nettype wire

//--- board_consts.svh
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

`default_nettype none

//----------------------------------------
// board clock
//----------------------------------------

// tang nano 9k crystal, MHz
`define CLK_MHZ 27

//----------------------------------------
// microphone i2s timing
//----------------------------------------

// clk cycles per SCK period, half high and half low
`define SCK_DIV 8

// SCK periods per frame, left slot then right slot
`define FRAME_SCK 64

// one sample per frame
`define SAMPLE_PERIOD (`SCK_DIV * `FRAME_SCK)

//----------------------------------------
// buffering and board wiring
//----------------------------------------

`define FIFO_DEPTH 8

// keys and leds are wired in reverse bit order on this board
`define REVERSE_KEY 1'b1
`define REVERSE_LED 1'b1

`default_nettype wire

`endif

//--- board_pkg.sv
`default_nettype none

package board_pkg;

    //----------------------------------------
    // lab side vectors
    //----------------------------------------

    // keys after inversion and reversal, 1 means pressed
    typedef logic [1:0] key_t;

    // leds before inversion and reversal, 1 means lit
    typedef logic [5:0] led_t;

    //----------------------------------------
    // key roles
    //----------------------------------------

    // values are bit positions in key_t
    typedef enum logic [0:0] {
        KEY_MUTE  = 1'b0,
        KEY_PAUSE = 1'b1
    } key_func_t;

endpackage

`default_nettype wire

//--- board_specific_top.sv
`include "board_consts.svh"

`default_nettype none
`timescale 1ns/100ps

module board_specific_top (
    input  wire        clk,
    input  wire        i_rst,
    input  wire  [1:0] i_key,
    input  wire        i_mic_sd,
    output logic [5:0] o_led,
    output logic       o_mic_sck,
    output logic       o_mic_ws,
    output logic       o_dac_p,
    output logic       o_dac_n
);

    localparam int w_key = $bits(board_pkg::key_t);
    localparam int w_led = $bits(board_pkg::led_t);

    board_pkg::key_t        lab_key;
    board_pkg::led_t        lab_led;

    logic                   mic_valid;
    logic                   mic_ready;
    audio_pkg::mic_sample_t mic_sample;
    logic                   mic_drop;

    logic                   play_valid;
    logic                   play_ready;
    audio_pkg::mic_sample_t play_sample;

    logic                   dac;
    logic [4:0]             level;
    logic                   drop_flag;

    //----------------------------------------
    // keys, active low on the board
    //----------------------------------------

    if (`REVERSE_KEY) begin : g_key_rev
        for (genvar i = 0; i < w_key; i++) begin : g_bit
            assign lab_key[i] = ~i_key[w_key - 1 - i];
        end
    end else begin : g_key_fwd
        assign lab_key = ~i_key;
    end

    //----------------------------------------
    // audio path
    //----------------------------------------

    inmp441_mic_i2s_receiver inmp441_mic_i2s_receiver_inst (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_sd     (i_mic_sd),
        .i_ready  (mic_ready),
        .o_sck    (o_mic_sck),
        .o_ws     (o_mic_ws),
        .o_valid  (mic_valid),
        .o_sample (mic_sample),
        .o_drop   (mic_drop)
    );

    sample_fifo #(
        .depth    (`FIFO_DEPTH)
    ) sample_fifo_inst (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_valid  (mic_valid),
        .i_sample (mic_sample),
        .i_ready  (play_ready),
        .o_ready  (mic_ready),
        .o_valid  (play_valid),
        .o_sample (play_sample)
    );

    sigma_delta_player sigma_delta_player_inst (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_valid  (play_valid),
        .i_sample (play_sample),
        .i_key    (lab_key),
        .o_ready  (play_ready),
        .o_dac    (dac),
        .o_level  (level)
    );

    // differential pin pair
    assign o_dac_p = dac;
    assign o_dac_n = ~dac;

    //----------------------------------------
    // leds
    //----------------------------------------

    // sticky until reset, shows any lost sample
    always_ff @(posedge clk) begin
        if (i_rst)
            drop_flag <= 1'b0;
        else if (mic_drop)
            drop_flag <= 1'b1;
    end

    assign lab_led = {drop_flag, level};

    // leds are active low
    if (`REVERSE_LED) begin : g_led_rev
        for (genvar i = 0; i < w_led; i++) begin : g_bit
            assign o_led[i] = ~lab_led[w_led - 1 - i];
        end
    end else begin : g_led_fwd
        assign o_led = ~lab_led;
    end

endmodule

`default_nettype wire

//--- inmp441_mic_i2s_receiver.sv
`include "board_consts.svh"

`default_nettype none
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver (
    input  wire                    clk,
    input  wire                    i_rst,
    input  wire                    i_sd,
    input  wire                    i_ready,
    output logic                   o_sck,
    output logic                   o_ws,
    output logic                   o_valid,
    output audio_pkg::mic_sample_t o_sample,
    output logic                   o_drop
);

    localparam int div_w    = $clog2(`SCK_DIV);
    localparam int period_w = $clog2(`FRAME_SCK);
    localparam int bits_w   = $clog2($bits(audio_pkg::mic_sample_t));

    localparam logic [div_w-1:0]    rise_at   = div_w'(`SCK_DIV / 2 - 1);
    localparam logic [div_w-1:0]    fall_at   = div_w'(`SCK_DIV - 1);
    localparam logic [period_w-1:0] last_per  = period_w'(`FRAME_SCK - 1);
    localparam logic [bits_w-1:0]   last_bit  = bits_w'($bits(audio_pkg::mic_sample_t) - 1);

    logic [div_w-1:0]       div_cnt;
    logic [period_w-1:0]    period_cnt;
    logic                   sck_rise;
    logic                   sck_fall;

    audio_pkg::mic_state_t  state;
    logic [bits_w-1:0]      bit_cnt;
    audio_pkg::mic_sample_t shift_reg;
    logic                   sample_done;

    //----------------------------------------
    // SCK and WS generation
    //----------------------------------------

    // both edges are decided one clk ahead so SCK comes straight from a flop
    assign sck_rise = (div_cnt == rise_at);
    assign sck_fall = (div_cnt == fall_at);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            div_cnt    <= '0;
            period_cnt <= '0;
            o_sck      <= 1'b0;
            o_ws       <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (sck_rise)
                o_sck <= 1'b1;
            if (sck_fall) begin
                o_sck      <= 1'b0;
                period_cnt <= period_cnt + 1'b1;
                // ws high for the second half of the frame (right slot)
                o_ws       <= (period_cnt + 1'b1) >= period_w'(`FRAME_SCK / 2);
            end
        end
    end

    //----------------------------------------
    // left slot capture
    //----------------------------------------

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state       <= audio_pkg::MIC_WAIT_FRAME;
            bit_cnt     <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= 1'b0;
            case (state)
                audio_pkg::MIC_WAIT_FRAME:
                    // only enter at the start of period 0, never mid-slot
                    if (period_cnt == '0 && !o_sck)
                        state <= audio_pkg::MIC_LEFT_DELAY;
                audio_pkg::MIC_LEFT_DELAY:
                    // i2s puts one idle bit after the ws edge
                    if (sck_rise) begin
                        bit_cnt <= '0;
                        state   <= audio_pkg::MIC_LEFT_DATA;
                    end
                audio_pkg::MIC_LEFT_DATA:
                    if (sck_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            sample_done <= 1'b1;
                            state       <= audio_pkg::MIC_SKIP;
                        end
                    end
                audio_pkg::MIC_SKIP:
                    // frame wraps on this falling edge
                    if (sck_fall && period_cnt == last_per)
                        state <= audio_pkg::MIC_LEFT_DELAY;
                default:
                    state <= audio_pkg::MIC_WAIT_FRAME;
            endcase
        end
    end

    // msb first
    always_ff @(posedge clk)
        if (state == audio_pkg::MIC_LEFT_DATA && sck_rise)
            shift_reg <= {shift_reg[$bits(shift_reg)-2:0], i_sd};

    //----------------------------------------
    // output holding register
    //----------------------------------------

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_drop  <= 1'b0;
        end else begin
            o_drop <= 1'b0;
            if (sample_done) begin
                o_valid <= 1'b1;
                // mic cannot wait, an untaken sample is overwritten
                o_drop  <= o_valid && !i_ready;
            end else if (o_valid && i_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
        if (sample_done)
            o_sample <= shift_reg;

endmodule

`default_nettype wire

//--- list.f
+incdir+.
audio_pkg.sv
board_pkg.sv
inmp441_mic_i2s_receiver.sv
sample_fifo.sv
sigma_delta_player.sv
board_specific_top.sv
tb_clock_gen.sv
tb_board_specific_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_specific_top -f list.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- sample_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module sample_fifo #(
    parameter int depth = 8
) (
    input  wire                    clk,
    input  wire                    i_rst,
    input  wire                    i_valid,
    input  wire audio_pkg::mic_sample_t i_sample,
    input  wire                    i_ready,
    output logic                   o_ready,
    output logic                   o_valid,
    output audio_pkg::mic_sample_t o_sample
);

    // depth must be a power of two so pointers wrap by themselves
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

    audio_pkg::mic_sample_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             push;
    logic             pop;

    //----------------------------------------
    // handshake
    //----------------------------------------

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    always_comb begin
        count_next = count;
        if (push && !pop)
            count_next = count + 1'b1;
        else if (pop && !push)
            count_next = count - 1'b1;
    end

    //----------------------------------------
    // pointers and flags
    //----------------------------------------

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_valid <= 1'b0;
            o_ready <= 1'b1;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count   <= count_next;
            // flags follow the next occupancy so both sides see flops
            o_valid <= (count_next != '0);
            o_ready <= (count_next != full_cnt);
        end
    end

    // storage
    always_ff @(posedge clk)
        if (push)
            mem[wr_ptr] <= i_sample;

    // head of queue, valid one cycle after its write
    assign o_sample = mem[rd_ptr];

endmodule

`default_nettype wire

//--- sigma_delta_player.sv
`include "board_consts.svh"

`default_nettype none
`timescale 1ns/100ps

module sigma_delta_player (
    input  wire                         clk,
    input  wire                         i_rst,
    input  wire                         i_valid,
    input  wire audio_pkg::mic_sample_t i_sample,
    input  wire board_pkg::key_t        i_key,
    output logic                        o_ready,
    output logic                        o_dac,
    output logic [4:0]                  o_level
);

    localparam int tick_w = $clog2(`SAMPLE_PERIOD);

    localparam logic [tick_w-1:0]   tick_at = tick_w'(`SAMPLE_PERIOD - 1);
    localparam audio_pkg::dac_code_t dac_mid = 8'h80;

    logic [tick_w-1:0]         tick_cnt;
    logic                      tick;
    logic                      key_mute;
    logic                      key_pause;

    audio_pkg::player_state_t  state;
    audio_pkg::dac_code_t      sample_code;
    audio_pkg::dac_code_t      new_code;
    audio_pkg::dac_code_t      dac_code;
    logic [8:0]                acc;
    logic [7:0]                mag;

    //----------------------------------------
    // sample period tick
    //----------------------------------------

    assign tick = (tick_cnt == tick_at);

    always_ff @(posedge clk) begin
        if (i_rst)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    //----------------------------------------
    // fetch and state
    //----------------------------------------

    assign key_mute  = i_key[board_pkg::KEY_MUTE];
    assign key_pause = i_key[board_pkg::KEY_PAUSE];

    // take exactly one sample per tick unless paused
    assign o_ready = tick && !key_pause && i_valid;

    // top byte to offset binary, flip the sign bit
    assign new_code = {~i_sample[23], i_sample[22:16]};

    // mode only changes on a tick so every window is one code
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state       <= audio_pkg::PLAYER_IDLE;
            sample_code <= dac_mid;
        end else if (tick) begin
            if (o_ready)
                sample_code <= new_code;
            case (state)
                audio_pkg::PLAYER_IDLE:
                    if (key_mute)
                        state <= audio_pkg::PLAYER_MUTED;
                    else if (o_ready)
                        state <= audio_pkg::PLAYER_PLAYING;
                audio_pkg::PLAYER_PLAYING:
                    if (key_mute)
                        state <= audio_pkg::PLAYER_MUTED;
                audio_pkg::PLAYER_MUTED:
                    // samples kept flowing while muted, resume from the latest
                    if (!key_mute)
                        state <= audio_pkg::PLAYER_PLAYING;
                default:
                    state <= audio_pkg::PLAYER_IDLE;
            endcase
        end
    end

    assign dac_code = (state == audio_pkg::PLAYER_PLAYING) ? sample_code : dac_mid;

    //----------------------------------------
    // first order sigma-delta
    //----------------------------------------

    // carry out of the 8-bit sum is the pulse stream
    always_ff @(posedge clk) begin
        if (i_rst)
            acc <= '0;
        else
            acc <= {1'b0, acc[7:0]} + {1'b0, dac_code};
    end

    assign o_dac = acc[8];

    //----------------------------------------
    // level meter
    //----------------------------------------

    // distance from midscale, 0 to 128
    always_comb begin
        if (dac_code[7])
            mag = {1'b0, dac_code[6:0]};
        else
            mag = dac_mid - dac_code;
        for (int n = 0; n < 5; n++)
            o_level[n] = (mag >= 8'(16 * (n + 1)));
    end

endmodule

`default_nettype wire

//--- tb_board_specific_top.sv
`include "board_consts.svh"

`default_nettype none
`timescale 1ns/100ps

module tb_board_specific_top;

    localparam int sp          = `SAMPLE_PERIOD;
    localparam int last_win    = 50;
    localparam int timeout_cyc = (last_win + 10) * sp;
    localparam int pipe_cap    = `FIFO_DEPTH + 1;

    // key schedule in sample periods and applied at mid-period
    localparam int mute_on_at   = 14;
    localparam int mute_off_at  = 22;
    localparam int pause_on_at  = 28;
    localparam int pause_off_at = 40;

    logic       clk;
    logic       rst;
    logic [1:0] key;
    logic       mic_sd;
    logic [5:0] led;
    logic       mic_sck;
    logic       mic_ws;
    logic       dac_p;
    logic       dac_n;

    // lab side key state where 1 means pressed
    logic       mute_on;
    logic       pause_on;

    int         cyc;
    logic       tests_done;

    // microphone model
    logic [31:0]            lfsr;
    logic                   prev_sck;
    int                     mic_period;
    audio_pkg::mic_sample_t mic_bits;
    audio_pkg::mic_sample_t mic_q [$];

    // reference model of the receiver hold plus fifo contents
    audio_pkg::mic_sample_t pipe_q [$];
    int                     held_code;
    int                     win_code [0:last_win + 1];
    int                     ones;
    logic                   model_drop;

    int wave_errs;
    int pair_errs;
    int code_errs;
    int led_errs;
    int end_errs;

    //----------------------------------------
    // model helpers
    //----------------------------------------

    // galois form of x^32 + x^22 + x^2 + x + 1 with the lsb as output bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ 32'h8020_0003;
        return shifted;
    endfunction

    // top byte with the sign flipped gives offset binary
    function automatic int code_of(input audio_pkg::mic_sample_t s);
        return int'(s[23:16] ^ 8'h80);
    endfunction

    function automatic logic [4:0] level_of(input int code);
        int         mag;
        logic [4:0] lvl;
        mag = (code >= 128) ? code - 128 : 128 - code;
        for (int i = 0; i < 5; i++)
            lvl[i] = (mag >= 16 * (i + 1));
        return lvl;
    endfunction

    // board keys are reversed and pull low when pressed
    function automatic logic [1:0] key_pins(input logic mute_key, input logic pause_key);
        board_pkg::key_t lab;
        logic [1:0]      pins;
        lab = '0;
        lab[board_pkg::KEY_MUTE]  = mute_key;
        lab[board_pkg::KEY_PAUSE] = pause_key;
        for (int i = 0; i < 2; i++)
            pins[1 - i] = ~lab[i];
        return pins;
    endfunction

    // undo led inversion and reversal
    function automatic board_pkg::led_t lab_leds(input logic [5:0] pins);
        board_pkg::led_t lab;
        for (int i = 0; i < 6; i++)
            lab[i] = ~pins[5 - i];
        return lab;
    endfunction

    //----------------------------------------
    // clock and DUT
    //----------------------------------------

    tb_clock_gen #(
        .period_ns (20)
    ) tb_clock_gen_inst (
        .o_clk     (clk)
    );

    board_specific_top board_specific_top_inst (
        .clk       (clk),
        .i_rst     (rst),
        .i_key     (key),
        .i_mic_sd  (mic_sd),
        .o_led     (led),
        .o_mic_sck (mic_sck),
        .o_mic_ws  (mic_ws),
        .o_dac_p   (dac_p),
        .o_dac_n   (dac_n)
    );

    //----------------------------------------
    // microphone model
    //----------------------------------------

    // a falling SCK seen here starts period next_per and SD changes right away
    always @(posedge clk) begin : mic_model
        int                     next_per;
        audio_pkg::mic_sample_t fresh;
        if (!rst) begin
            prev_sck <= mic_sck;
            if (prev_sck && !mic_sck) begin
                next_per = (mic_period + 1) % `FRAME_SCK;
                mic_period <= next_per;
                if (next_per == 1) begin
                    // msb goes out one bit after the ws edge
                    fresh = '0;
                    for (int b = 0; b < 24; b++) begin
                        fresh = {fresh[22:0], lfsr[0]};
                        lfsr  = lfsr_next(lfsr);
                    end
                    mic_q.push_back(fresh);
                    mic_bits <= fresh;
                    mic_sd   <= fresh[23];
                end else if (next_per >= 2 && next_per <= 24) begin
                    mic_sd <= mic_bits[24 - next_per];
                end else begin
                    mic_sd <= 1'b0;
                end
            end
        end
    end

    //----------------------------------------
    // SCK, WS and DAC pair
    //----------------------------------------

    // values read here were set by edge number cyc
    always @(posedge clk) begin : wave_check
        logic exp_sck;
        logic exp_ws;
        if (!rst) begin
            exp_sck = (cyc % `SCK_DIV) >= (`SCK_DIV / 2);
            exp_ws  = ((cyc / `SCK_DIV) % `FRAME_SCK) >= (`FRAME_SCK / 2);
            assert (mic_sck == exp_sck && mic_ws == exp_ws) else begin
                wave_errs++;
                $display("error: time %0t sck %b ws %b, expected sck %b ws %b",
                         $time, mic_sck, mic_ws, exp_sck, exp_ws);
            end
            assert (dac_n == ~dac_p) else begin
                pair_errs++;
                $display("error: time %0t dac_n %b is not the complement of dac_p %b",
                         $time, dac_n, dac_p);
            end
        end
    end

    //----------------------------------------
    // reference model and window checks
    //----------------------------------------

    always @(posedge clk) begin : window_check
        int              n;
        int              k;
        int              phase;
        int              c;
        logic            nm;
        logic            np;
        board_pkg::led_t lab;
        if (!rst) begin
            n = cyc + 1;
            cyc <= n;
            k     = n / sp;
            phase = n % sp;

            // tick k fetches one sample in fifo order unless paused
            if (phase == 0 && k <= last_win + 1) begin
                if (!pause_on && pipe_q.size() > 0)
                    held_code = code_of(pipe_q.pop_front());
                win_code[k] = mute_on ? 128 : held_code;
            end

            // dac lags the code by two edges
            if (phase == 2) begin
                if (k >= 1 && k - 1 <= last_win) begin
                    c = win_code[k - 1];
                    assert (ones >= 2 * c - 1 && ones <= 2 * c + 1) else begin
                        code_errs++;
                        $display("error: time %0t window %0d has %0d ones, expected %0d +- 1",
                                 $time, k - 1, ones, 2 * c);
                    end
                    if (k - 1 == last_win)
                        tests_done <= 1'b1;
                end
                ones <= dac_p ? 1 : 0;
            end else begin
                ones <= ones + (dac_p ? 1 : 0);
            end

            // sample k is in by mid-period
            if (phase == sp / 2 && k <= last_win) begin
                assert (mic_q.size() > 0) else begin
                    code_errs++;
                    $display("microphone model produced no sample in period %0d", k);
                end
                if (mic_q.size() > 0) begin
                    if (pipe_q.size() == pipe_cap) begin
                        // receiver overwrites its newest held sample
                        pipe_q.delete(pipe_q.size() - 1);
                        model_drop = 1'b1;
                    end
                    pipe_q.push_back(mic_q.pop_front());
                end

                lab = lab_leds(led);
                assert (lab[4:0] == level_of(win_code[k])) else begin
                    led_errs++;
                    $display("error: time %0t level leds %b, expected %b for code %0d",
                             $time, lab[4:0], level_of(win_code[k]), win_code[k]);
                end
                assert (lab[5] == model_drop) else begin
                    led_errs++;
                    $display("error: time %0t drop led %b, expected %b",
                             $time, lab[5], model_drop);
                end

                nm = mute_on;
                np = pause_on;
                if (k == mute_on_at)
                    nm = 1'b1;
                if (k == mute_off_at)
                    nm = 1'b0;
                if (k == pause_on_at)
                    np = 1'b1;
                if (k == pause_off_at)
                    np = 1'b0;
                mute_on  <= nm;
                pause_on <= np;
                key      <= key_pins(nm, np);
            end
        end
    end

    //----------------------------------------
    // run control
    //----------------------------------------

    initial begin
        board_pkg::led_t end_leds;
        rst        = 1'b1;
        key        = key_pins(1'b0, 1'b0);
        mic_sd     = 1'b0;
        mute_on    = 1'b0;
        pause_on   = 1'b0;
        tests_done = 1'b0;
        cyc        = 0;
        lfsr       = 32'h12ea303e;
        prev_sck   = 1'b0;
        mic_period = 0;
        mic_bits   = '0;
        held_code  = 128;
        ones       = 0;
        model_drop = 1'b0;
        wave_errs  = 0;
        pair_errs  = 0;
        code_errs  = 0;
        led_errs   = 0;
        end_errs   = 0;
        for (int i = 0; i <= last_win + 1; i++)
            win_code[i] = 128;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        while (!tests_done && cyc < timeout_cyc)
            @(posedge clk);

        if (!tests_done) begin
            $display("timeout, the last window was not reached after %0d cycles", cyc);
        end else begin
            // the drop led stays lit after the pause overflow
            end_leds = lab_leds(led);
            assert (end_leds[5]) else begin
                end_errs++;
                $display("the drop led was dark at the end of the run");
            end
        end

        $display("errors: waveform %0d, dac pair %0d, code %0d, led %0d, end %0d",
                 wave_errs, pair_errs, code_errs, led_errs, end_errs);
        if (tests_done && wave_errs + pair_errs + code_errs + led_errs + end_errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns = 20
) (
    output logic o_clk
);

    // free running, starts low so the first rising edge is half a period in
    initial o_clk = 1'b0;

    always #(period_ns / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire
